// File: build.f
design/rv32v_mask_pkg.sv
design/encoder.sv
design/tree_adder_8bit.sv
design/mask_unit.sv
design/iota_unit.sv
design/mask_lane.sv
verification/mask_lane_tb.sv

// File: Bender.yml
package:
  name: rv32v_mask_lane

sources:
  # Package first, then leaf blocks, then the lane top
  - files:
      - design/rv32v_mask_pkg.sv
      - design/encoder.sv
      - design/tree_adder_8bit.sv
      - design/mask_unit.sv
      - design/iota_unit.sv
      - design/mask_lane.sv

  # Testbench, top module mask_lane_tb
  - target: test
    files:
      - verification/mask_lane_tb.sv

// File: verification/mask_lane_tb.sv
// Self-checking testbench for the mask lane, run as the simulation top from build.f
`timescale 1ns/10ps
`default_nettype none

module mask_lane_tb;

  import rv32v_mask_pkg::*;

  // Number of hand-checked rows in the stimulus table
  localparam int N_TAB      = 39;
  // Number of random logical-op words after the table
  localparam int N_RAND     = 40;
  // Table plus random words plus room for reset and pipeline drain, in ns
  localparam int TIMEOUT_NS = (N_TAB + N_RAND + 20) * 10;

  // One stimulus word with the result the lane must produce for it
  typedef struct packed {
    mask_op_e op;
    logic     in_inv;
    logic     out_inv;
    logic     iota_start;
    word_t    vs1;
    word_t    vs2;
    word_t    msk;
    word_t    exp;
  } row_t;

  logic     clk;
  logic     rst_n;
  logic     valid_in;
  mask_op_e mask_type;
  logic     in_inv;
  logic     out_inv;
  logic     iota_start;
  word_t    vs1_data;
  word_t    vs2_data;
  word_t    mask_data;
  logic     valid_out;
  word_t    wdata;

  row_t     tab [N_TAB];
  int       n_rows;
  // Expected results and the edge count when each word was driven, oldest first
  word_t    exp_q [$];
  int       edge_q [$];
  int       edge_cnt;
  int       n_sent;
  int       n_recv;
  word_t    got_exp;
  int       got_edge;
  integer   seed;

  mask_lane UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_in   (valid_in),
    .mask_type  (mask_type),
    .in_inv     (in_inv),
    .out_inv    (out_inv),
    .iota_start (iota_start),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .mask_data  (mask_data),
    .valid_out  (valid_out),
    .wdata      (wdata)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  // Rising edges seen so far, used to measure the latency of each word
  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped after the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // Logical op result built straight from the instruction rules
  function automatic word_t logic_expect(input mask_op_e op, input logic ii, input logic oi,
                                         input word_t vs1, input word_t vs2);
    word_t b;
    word_t r;
    b = ii ? ~vs1 : vs1;
    case (op)
      VMASK_AND: r = vs2 & b;
      VMASK_OR:  r = vs2 | b;
      default:   r = vs2 ^ b;
    endcase
    if (oi) begin
      r = ~r;
    end
    return r;
  endfunction

  task automatic add_row(input mask_op_e op, input logic ii, input logic oi, input logic st,
                         input word_t vs1, input word_t vs2, input word_t msk,
                         input word_t exp);
    tab[n_rows].op         = op;
    tab[n_rows].in_inv     = ii;
    tab[n_rows].out_inv    = oi;
    tab[n_rows].iota_start = st;
    tab[n_rows].vs1        = vs1;
    tab[n_rows].vs2        = vs2;
    tab[n_rows].msk        = msk;
    tab[n_rows].exp        = exp;
    n_rows++;
  endtask

  // Drives one word at a falling edge and books its expected result
  task automatic apply_word(input mask_op_e op, input logic ii, input logic oi, input logic st,
                            input word_t vs1, input word_t vs2, input word_t msk,
                            input word_t exp);
    valid_in   = 1'b1;
    mask_type  = op;
    in_inv     = ii;
    out_inv    = oi;
    iota_start = st;
    vs1_data   = vs1;
    vs2_data   = vs2;
    mask_data  = msk;
    exp_q.push_back(exp);
    // The sampling edge and the result edge are the next two after this count
    edge_q.push_back(edge_cnt);
    n_sent++;
    @(negedge clk);
  endtask

  task automatic load_table();
    // and, andn, nand and andn with output inversion on vs2 F0F0_A5A5, vs1 FF00_3C3C
    add_row(VMASK_AND, 0, 0, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'hF000_2424);
    add_row(VMASK_AND, 1, 0, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'h00F0_8181);
    add_row(VMASK_AND, 0, 1, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'h0FFF_DBDB);
    add_row(VMASK_AND, 1, 1, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'hFF0F_7E7E);
    add_row(VMASK_OR,  0, 0, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'hFFF0_BDBD);
    add_row(VMASK_OR,  1, 0, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'hF0FF_E7E7);
    add_row(VMASK_OR,  0, 1, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'h000F_4242);
    add_row(VMASK_OR,  1, 1, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'h0F00_1818);
    add_row(VMASK_XOR, 0, 0, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'h0FF0_9999);
    add_row(VMASK_XOR, 1, 0, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'hF00F_6666);
    add_row(VMASK_XOR, 0, 1, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'hF00F_6666);
    add_row(VMASK_XOR, 1, 1, 0, 32'hFF00_3C3C, 32'hF0F0_A5A5, 32'h0, 32'h0FF0_9999);
    // The flags must not change the population counts
    add_row(VMASK_POPC, 0, 0, 0, 32'h0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0020);
    add_row(VMASK_POPC, 1, 1, 0, 32'h0, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000);
    add_row(VMASK_POPC, 0, 0, 0, 32'h0, 32'h8000_0001, 32'hFFFF_FFFF, 32'h0000_0002);
    add_row(VMASK_POPC, 0, 0, 0, 32'h0, 32'hF0F0_A5A5, 32'h0F0F_FFFF, 32'h0000_0008);
    // In the second find-first row the lowest vs2 bit is masked off
    add_row(VMASK_FIRST, 0, 0, 0, 32'h0, 32'h0000_0100, 32'hFFFF_FFFF, 32'h0000_0008);
    add_row(VMASK_FIRST, 0, 0, 0, 32'h0, 32'h0000_0101, 32'hFFFF_FFFE, 32'h0000_0008);
    add_row(VMASK_FIRST, 0, 0, 0, 32'h0, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_001F);
    add_row(VMASK_FIRST, 0, 0, 0, 32'h0, 32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF);
    // Set-before, set-including and set-only first at index 8, index 31 and empty
    add_row(VMASK_SBF, 0, 0, 0, 32'h0, 32'h0000_0100, 32'hFFFF_FFFF, 32'h0000_00FF);
    add_row(VMASK_SIF, 0, 0, 0, 32'h0, 32'h0000_0100, 32'hFFFF_FFFF, 32'h0000_01FF);
    add_row(VMASK_SOF, 0, 0, 0, 32'h0, 32'h0000_0100, 32'hFFFF_FFFF, 32'h0000_0100);
    add_row(VMASK_SBF, 0, 0, 0, 32'h0, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF);
    add_row(VMASK_SIF, 0, 0, 0, 32'h0, 32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_row(VMASK_SOF, 0, 0, 0, 32'h0, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_row(VMASK_SBF, 0, 0, 0, 32'h0, 32'h0000_0003, 32'h0000_0000, 32'hFFFF_FFFF);
    add_row(VMASK_SIF, 0, 0, 0, 32'h0, 32'h0000_0003, 32'h0000_0000, 32'hFFFF_FFFF);
    add_row(VMASK_SOF, 0, 0, 0, 32'h0, 32'h0000_0003, 32'h0000_0000, 32'h0000_0000);
    add_row(VMASK_SIF, 0, 0, 0, 32'h0, 32'h0000_0060, 32'hFFFF_FFDF, 32'h0000_007F);
    // Two viota sequences where a POPC word in the middle leaves the running count alone
    add_row(VMASK_IOTA, 0, 0, 1, 32'h0, 32'h0000_000F, 32'h0000_FFFF, 32'h0000_0000);
    add_row(VMASK_IOTA, 0, 0, 0, 32'h0, 32'hFFFF_FFFF, 32'h0000_FF00, 32'h0000_0004);
    add_row(VMASK_IOTA, 0, 0, 0, 32'h0, 32'h0000_0001, 32'h0000_0001, 32'h0000_000C);
    add_row(VMASK_POPC, 0, 0, 0, 32'h0, 32'h0000_0003, 32'hFFFF_FFFF, 32'h0000_0002);
    add_row(VMASK_IOTA, 0, 0, 0, 32'h0, 32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_000D);
    add_row(VMASK_IOTA, 0, 0, 1, 32'h0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
    add_row(VMASK_IOTA, 0, 0, 0, 32'h0, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0020);
    add_row(VMASK_IOTA, 0, 0, 0, 32'h0, 32'h0000_FFFF, 32'hFFFF_FFFF, 32'h0000_0020);
    add_row(VMASK_IOTA, 0, 0, 0, 32'h0, 32'h0000_0000, 32'h0000_0000, 32'h0000_0030);
  endtask

  // Checks every result on the falling edge, where wdata and valid_out are settled
  always @(negedge clk) begin
    if (rst_n && valid_out) begin
      if (exp_q.size() == 0) begin
        abort_run("valid_out pulsed while no word was in flight");
      end else begin
        got_exp  = exp_q.pop_front();
        got_edge = edge_q.pop_front();
        check_value("wdata", wdata, got_exp);
        // Two rising edges from the word's input to its result
        check_value("latency_edges", edge_cnt - got_edge, 2);
        n_recv++;
      end
    end
  end

  // Watchdog that ends a run which stops making progress
  initial begin
    #(TIMEOUT_NS);
    abort_run("Timeout: the lane did not return all results in time");
  end

  initial begin
    logic [31:0] r;
    mask_op_e    op;
    word_t       a;
    word_t       b;
    word_t       m;
    seed       = 32'h2d7d_1492;
    clk        = 1'b0;
    rst_n      = 1'b0;
    valid_in   = 1'b0;
    mask_type  = VMASK_AND;
    in_inv     = 1'b0;
    out_inv    = 1'b0;
    iota_start = 1'b0;
    vs1_data   = '0;
    vs2_data   = '0;
    mask_data  = '0;
    edge_cnt   = 0;
    n_rows     = 0;
    n_sent     = 0;
    n_recv     = 0;
    load_table();
    if (n_rows != N_TAB) begin
      abort_run("Stimulus table holds a different number of rows than declared");
    end
    // Outputs must stay at their reset values while rst_n is low
    repeat (5) begin
      @(negedge clk);
      check_value("valid_out", valid_out, 0);
      check_value("wdata", wdata, 0);
    end
    rst_n = 1'b1;
    // Table words go out back to back, one per cycle
    for (int i = 0; i < N_TAB; i++) begin
      apply_word(tab[i].op, tab[i].in_inv, tab[i].out_inv, tab[i].iota_start,
                 tab[i].vs1, tab[i].vs2, tab[i].msk, tab[i].exp);
    end
    // Random logical ops with random flags
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      m = $random(seed);
      case (r % 3)
        0:       op = VMASK_AND;
        1:       op = VMASK_OR;
        default: op = VMASK_XOR;
      endcase
      apply_word(op, r[4], r[5], r[6], a, b, m, logic_expect(op, r[4], r[5], a, b));
    end
    valid_in = 1'b0;
    wait (n_recv == n_sent);
    // A couple of idle cycles catch any extra valid_out pulse
    repeat (3) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/mask_lane.sv
// Top of the vector mask lane with a two-cycle pipeline around the mask datapath and the viota accumulator
`timescale 1ns/10ps
`default_nettype none

module mask_lane (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_in,
  input  rv32v_mask_pkg::mask_op_e mask_type,
  input  logic                     in_inv,
  input  logic                     out_inv,
  input  logic                     iota_start,
  input  rv32v_mask_pkg::word_t    vs1_data,
  input  rv32v_mask_pkg::word_t    vs2_data,
  input  rv32v_mask_pkg::word_t    mask_data,
  output logic                     valid_out,
  output rv32v_mask_pkg::word_t    wdata
);

  import rv32v_mask_pkg::*;

  // Control part of the operand stage
  logic     valid_q;
  mask_op_e op_q;
  logic     in_inv_q;
  logic     out_inv_q;
  logic     iota_start_q;

  // Data words of the operand stage
  word_t    vs1_q;
  word_t    vs2_q;
  word_t    mask_q;

  // Datapath wires between the operand and result stages
  word_t    wdata_m;
  word_t    iota_res;
  cnt_t     popc_count;
  logic     is_iota;

  // Control registers take a new word only when the producer strobes valid_in
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= 1'b0;
      op_q         <= VMASK_AND;
      in_inv_q     <= 1'b0;
      out_inv_q    <= 1'b0;
      iota_start_q <= 1'b0;
    end else begin
      valid_q <= valid_in;
      if (valid_in) begin
        op_q         <= mask_type;
        in_inv_q     <= in_inv;
        out_inv_q    <= out_inv;
        iota_start_q <= iota_start;
      end
    end
  end

  // Data words are held from one valid word to the next
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vs1_q  <= '0;
      vs2_q  <= '0;
      mask_q <= '0;
    end else if (valid_in) begin
      vs1_q  <= vs1_data;
      vs2_q  <= vs2_data;
      mask_q <= mask_data;
    end
  end

  // Only a staged viota word may move the running count
  assign is_iota = (op_q == VMASK_IOTA);

  mask_unit U_MASK (
    .mask_type  (op_q),
    .in_inv     (in_inv_q),
    .out_inv    (out_inv_q),
    .vs1_data   (vs1_q),
    .vs2_data   (vs2_q),
    .mask_data  (mask_q),
    .iota_res   (iota_res),
    .wdata_m    (wdata_m),
    .popc_count (popc_count)
  );

  iota_unit U_IOTA (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid      (valid_q),
    .is_iota    (is_iota),
    .iota_start (iota_start_q),
    .popc_count (popc_count),
    .iota_res   (iota_res)
  );

  // The result stage loads at the edge after the operand stage
  // wdata holds its last value between results and reads zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
      wdata     <= '0;
    end else begin
      valid_out <= valid_q;
      if (valid_q) begin
        wdata <= wdata_m;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/iota_unit.sv
// Running prefix count of active mask bits that gives viota its base value for each word of a sequence
`timescale 1ns/10ps
`default_nettype none

module iota_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid,
  input  logic                  is_iota,
  input  logic                  iota_start,
  input  rv32v_mask_pkg::cnt_t  popc_count,
  output rv32v_mask_pkg::word_t iota_res
);

  import rv32v_mask_pkg::*;

  // Set bits seen over all earlier IOTA words of the current sequence
  // Kept a full word wide since a long sequence passes 63 quickly
  word_t acc;
  // Popcount of the word in the operand stage, widened to the accumulator
  word_t popc_word;
  // High for exactly the cycles that move the accumulator
  logic  acc_en;

  assign popc_word = word_t'(popc_count);
  assign acc_en    = valid & is_iota;

  // A start word has no predecessors, so it always sees zero
  // Later words see the sum built up by the words before them
  assign iota_res = iota_start ? '0 : acc;

  // On a start word the current count becomes the new base
  // Otherwise the current count is added on top of the old sum
  // Non-IOTA words pass through without touching the sum
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (acc_en) begin
      if (iota_start) begin
        acc <= popc_word;
      end else begin
        acc <= acc + popc_word;
      end
    end
  end

  // The result of a word never includes its own popcount
  // That is the exclusive prefix sum viota.m asks for
  // The update lands at the edge that also captures the lane result

endmodule

`default_nettype wire

// File: design/mask_unit.sv
// Combinational mask-op datapath of the lane, placed between the operand and result registers of mask_lane
`timescale 1ns/10ps
`default_nettype none

module mask_unit (
  input  rv32v_mask_pkg::mask_op_e mask_type,
  input  logic                     in_inv,
  input  logic                     out_inv,
  input  rv32v_mask_pkg::word_t    vs1_data,
  input  rv32v_mask_pkg::word_t    vs2_data,
  input  rv32v_mask_pkg::word_t    mask_data,
  input  rv32v_mask_pkg::word_t    iota_res,
  output rv32v_mask_pkg::word_t    wdata_m,
  output rv32v_mask_pkg::cnt_t     popc_count
);

  import rv32v_mask_pkg::*;

  // Active source bits after the v0 mask is applied
  word_t     src;
  // Second logical operand, optionally inverted for the andn/orn forms
  word_t     in1;
  // All ones when out_inv is set, XORed onto the logical results
  word_t     out_flip;
  word_t     and_res, or_res, xor_res;
  // Per-byte set-bit counts
  byte_cnt_t cnt0, cnt1, cnt2, cnt3;
  // Low when src has no set bit at all
  logic      found;
  bit_idx_t  first_idx;
  word_t     first_res, sbf_res, sif_res, sof_res;

  assign src      = vs2_data & mask_data;
  assign in1      = in_inv ? ~vs1_data : vs1_data;
  assign out_flip = {WORD_W{out_inv}};

  assign and_res = (vs2_data & in1) ^ out_flip;
  assign or_res  = (vs2_data | in1) ^ out_flip;
  assign xor_res = (vs2_data ^ in1) ^ out_flip;

  encoder ENC (
    .in     (vs2_data),
    .ena    (mask_data),
    .strobe (found),
    .out    (first_idx)
  );

  tree_adder_8bit TA0 (.add_in(src[7:0]),   .add_out(cnt0));
  tree_adder_8bit TA1 (.add_in(src[15:8]),  .add_out(cnt1));
  tree_adder_8bit TA2 (.add_in(src[23:16]), .add_out(cnt2));
  tree_adder_8bit TA3 (.add_in(src[31:24]), .add_out(cnt3));

  // Sum of the four bytes, zero extended so that 32 fits
  assign popc_count = {2'b00, cnt0} + {2'b00, cnt1} + {2'b00, cnt2} + {2'b00, cnt3};

  // vfirst returns -1 on an empty source, which is all ones in the word
  assign first_res = found ? word_t'(first_idx) : '1;

  // Everything below the first set bit
  assign sbf_res = found ? ~({WORD_W{1'b1}} << first_idx) : '1;
  // The two-step shift keeps index 31 correct, the mask then covers the whole word
  assign sif_res = found ? ~(({WORD_W{1'b1}} << first_idx) << 1) : '1;
  // Only the first set bit, nothing when the source is empty
  assign sof_res = found ? (word_t'(1) << first_idx) : '0;

  always_comb begin
    case (mask_type)
      VMASK_AND   : wdata_m = and_res;
      VMASK_OR    : wdata_m = or_res;
      VMASK_XOR   : wdata_m = xor_res;
      VMASK_POPC  : wdata_m = word_t'(popc_count);
      VMASK_FIRST : wdata_m = first_res;
      VMASK_SBF   : wdata_m = sbf_res;
      VMASK_SIF   : wdata_m = sif_res;
      VMASK_SOF   : wdata_m = sof_res;
      VMASK_IOTA  : wdata_m = iota_res;
      default     : wdata_m = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/tree_adder_8bit.sv
// Population count of one byte as a three-level adder tree, instantiated four times by the mask datapath
`timescale 1ns/10ps
`default_nettype none

module tree_adder_8bit (
  input  logic [7:0]                add_in,
  output rv32v_mask_pkg::byte_cnt_t add_out
);

  // First level adds neighbouring bits into 2-bit pair sums
  logic [1:0] pair0, pair1, pair2, pair3;
  // Second level adds pairs into 3-bit quad sums, 0 to 4
  logic [2:0] quad0, quad1;

  assign pair0 = {1'b0, add_in[0]} + {1'b0, add_in[1]};
  assign pair1 = {1'b0, add_in[2]} + {1'b0, add_in[3]};
  assign pair2 = {1'b0, add_in[4]} + {1'b0, add_in[5]};
  assign pair3 = {1'b0, add_in[6]} + {1'b0, add_in[7]};

  assign quad0 = {1'b0, pair0} + {1'b0, pair1};
  assign quad1 = {1'b0, pair2} + {1'b0, pair3};

  // Last level widens once more so a full byte can reach 8
  assign add_out = {1'b0, quad0} + {1'b0, quad1};

endmodule

`default_nettype wire

// File: design/encoder.sv
// Priority encoder that finds the lowest enabled set bit of a word, used by the mask datapath for vfirst and vms*f
`timescale 1ns/10ps
`default_nettype none

module encoder (
  input  rv32v_mask_pkg::word_t    in,
  input  rv32v_mask_pkg::word_t    ena,
  output logic                     strobe,
  output rv32v_mask_pkg::bit_idx_t out
);

  import rv32v_mask_pkg::*;

  // Only bits that are both set and enabled can be reported
  word_t hits;

  assign hits = in & ena;

  // Walk from the top bit down so that the last match written is the lowest one
  // This keeps bit 0 at the highest priority without a break out of the loop
  always_comb begin
    strobe = 1'b0;
    out    = '0;
    for (int i = WORD_W - 1; i >= 0; i--) begin
      if (hits[i]) begin
        strobe = 1'b1;
        out    = bit_idx_t'(i);
      end
    end
  end

  // With no hit the loop leaves strobe low and out at zero
  // Consumers look at strobe before they trust out

endmodule

`default_nettype wire

// File: design/rv32v_mask_pkg.sv
// Shared word, index and count types plus the mask-op encoding, imported by the lane RTL and its testbench
`default_nettype none

package rv32v_mask_pkg;

  // Word width of the lane, fixed by the 32-bit mask register slice
  localparam int unsigned WORD_W = 32;

  // One mask word, one vector operand or one result word
  typedef logic [WORD_W-1:0] word_t;

  // Position of a single bit inside a word
  typedef logic [4:0] bit_idx_t;

  // Set bits in one byte, 0 to 8, so four bits are needed
  typedef logic [3:0] byte_cnt_t;

  // Set bits in one word, 0 to 32
  // Six bits are required because a full word counts to 32
  typedef logic [5:0] cnt_t;

  // Mask instruction select
  // The n/nor/nand/xnor forms are not separate codes
  // They come from AND, OR and XOR combined with the in_inv and out_inv flags
  typedef enum logic [3:0] {
    // vmand, vmandn, vmnand
    VMASK_AND   = 4'd0,
    // vmor, vmorn, vmnor
    VMASK_OR    = 4'd1,
    // vmxor, vmxnor
    VMASK_XOR   = 4'd2,
    // vcpop.m
    VMASK_POPC  = 4'd3,
    // vfirst.m
    VMASK_FIRST = 4'd4,
    // vmsbf.m
    VMASK_SBF   = 4'd5,
    // vmsif.m
    VMASK_SIF   = 4'd6,
    // vmsof.m
    VMASK_SOF   = 4'd7,
    // viota.m, one word of a longer sequence
    VMASK_IOTA  = 4'd8
  } mask_op_e;

endpackage

`default_nettype wire
